//--- bus_pkg.sv
// Instruction bus types
// Address and data words seen on the instruction memory port

package bus_pkg;

  ///////////////////////////////////////////////////
  // Bus widths
  ///////////////////////////////////////////////////

  // Byte address of an instruction word
  typedef logic [31:0] addr_t;

  // One 32-bit instruction word as returned by memory
  typedef logic [31:0] word_t;

  // Distance between two sequential fetches
  localparam addr_t WORD_BYTES = addr_t'(4);

endpackage

//--- prefetch_pkg.sv
// Prefetch buffer definitions
// Fetch controller states and the default FIFO sizing

package prefetch_pkg;

  ///////////////////////////////////////////////////
  // Fetch controller FSM
  ///////////////////////////////////////////////////

  // Idle: nothing outstanding on the bus
  // Wait grant: request raised but not yet accepted
  // Wait rvalid: one response outstanding, will be kept
  // Wait aborted: one response outstanding, will be dropped
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID,
    FETCH_WAIT_ABORTED
  } fetch_state_e;

  ///////////////////////////////////////////////////
  // FIFO sizing
  ///////////////////////////////////////////////////

  // Needs at least two entries for the space threshold to work
  localparam int unsigned FIFO_DEPTH_DEF = 2;

endpackage

//--- obi_fetch_port.sv
// Instruction memory port with req/gnt/rvalid handshake
// Optionally keeps request and address stable until the grant

module obi_fetch_port #(
  parameter bit TRANS_STABLE_OFF = 1'b0
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              trans_valid_i,
  input  bus_pkg::addr_t    trans_addr_i,
  output logic              trans_ready_o,
  output logic              resp_valid_o,
  output bus_pkg::word_t    resp_rdata_o,
  output logic              instr_req_o,
  output bus_pkg::addr_t    instr_addr_o,
  input  logic              instr_gnt_i,
  input  bus_pkg::word_t    instr_rdata_i,
  input  logic              instr_rvalid_i
);

  import bus_pkg::*;

  // Bus only carries word accesses
  addr_t trans_addr_aligned;

  assign trans_addr_aligned = {trans_addr_i[31:2], 2'b00};

  // Response side is a plain pass-through
  assign resp_valid_o = instr_rvalid_i;
  assign resp_rdata_o = instr_rdata_i;

  if (TRANS_STABLE_OFF) begin : g_pass
    // Legacy behavior, address may move during a waited transfer
    assign instr_req_o   = trans_valid_i;
    assign instr_addr_o  = trans_addr_aligned;
    assign trans_ready_o = instr_gnt_i;
  end else begin : g_stable
    typedef enum logic {PORT_PASS, PORT_HOLD} port_state_e;

    port_state_e state_q;
    port_state_e state_d;
    addr_t       addr_q;

    always_comb begin
      state_d = state_q;
      if (state_q == PORT_PASS) begin
        // Transaction is taken over here, granted now or held below
        instr_req_o   = trans_valid_i;
        instr_addr_o  = trans_addr_aligned;
        trans_ready_o = 1'b1;
        if (trans_valid_i && !instr_gnt_i) begin
          state_d = PORT_HOLD;
        end
      end else begin
        // Replay the captured request until memory grants it
        instr_req_o   = 1'b1;
        instr_addr_o  = addr_q;
        trans_ready_o = 1'b0;
        if (instr_gnt_i) begin
          state_d = PORT_PASS;
        end
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        state_q <= PORT_PASS;
      end else begin
        state_q <= state_d;
      end
    end

    // Capture address while transparent, frozen while holding
    always_ff @(posedge clk) begin
      if (state_q == PORT_PASS) begin
        addr_q <= trans_addr_aligned;
      end
    end
  end

endmodule

//--- prefetch_ctrl.sv
// Prefetch controller
// Issues sequential word fetches, restarts at branch targets, drops aborted responses

module prefetch_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  logic              branch_i,
  input  bus_pkg::addr_t    branch_addr_i,
  input  logic              trans_ready_i,
  input  logic              resp_valid_i,
  input  logic              fifo_space_i,
  output logic              trans_valid_o,
  output bus_pkg::addr_t    trans_addr_o,
  output logic              resp_keep_o,
  output logic              busy_o
);

  import bus_pkg::*;
  import prefetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // Last accepted fetch address, kept word aligned
  addr_t instr_addr_q;
  addr_t fetch_addr;
  logic  addr_valid;
  logic  fetch_ok;

  assign fetch_addr = instr_addr_q + WORD_BYTES;

  // A branch always gets through, sequential fetch needs room
  assign fetch_ok = req_i && (fifo_space_i || branch_i);

  ///////////////////////////////////////////////////
  // Next state and request logic
  ///////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    trans_valid_o = 1'b0;
    trans_addr_o  = branch_i ? branch_addr_i : fetch_addr;
    addr_valid    = 1'b0;

    unique case (state_q)
      FETCH_IDLE: begin
        if (fetch_ok) begin
          trans_valid_o = 1'b1;
          addr_valid    = 1'b1;
          state_d       = trans_ready_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      FETCH_WAIT_GNT: begin
        // Keep requesting; a branch redirects the pending request
        trans_valid_o = 1'b1;
        if (branch_i) begin
          addr_valid = 1'b1;
        end else begin
          trans_addr_o = instr_addr_q;
        end
        if (trans_ready_i) begin
          state_d = FETCH_WAIT_RVALID;
        end
      end

      FETCH_WAIT_RVALID: begin
        if (resp_valid_i) begin
          // Next request goes out in the response cycle
          if (fetch_ok) begin
            trans_valid_o = 1'b1;
            addr_valid    = 1'b1;
            state_d       = trans_ready_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
          end else begin
            state_d = FETCH_IDLE;
          end
        end else if (branch_i) begin
          // Response still on its way, remember target and drop it later
          addr_valid = 1'b1;
          state_d    = FETCH_WAIT_ABORTED;
        end
      end

      FETCH_WAIT_ABORTED: begin
        if (branch_i) begin
          addr_valid = 1'b1;
        end else begin
          trans_addr_o = instr_addr_q;
        end
        // Stale response arrives, request the target right away
        if (resp_valid_i) begin
          trans_valid_o = 1'b1;
          state_d       = trans_ready_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  // Response in aborted state belongs to the old stream
  assign resp_keep_o = (state_q != FETCH_WAIT_ABORTED);
  assign busy_o      = (state_q != FETCH_IDLE);

  ///////////////////////////////////////////////////
  // State and address registers
  ///////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= FETCH_IDLE;
      instr_addr_q <= '0;
    end else begin
      state_q <= state_d;
      if (addr_valid) begin
        // Low bits dropped so the next step lands on a word
        instr_addr_q <= trans_addr_o & ~(WORD_BYTES - addr_t'(1));
      end
    end
  end

endmodule

//--- fetch_fifo.sv
// Instruction FIFO between memory port and decoder
// Bypasses a kept response when empty; flush empties it for the next cycle

module fetch_fifo #(
  parameter int unsigned FIFO_DEPTH = prefetch_pkg::FIFO_DEPTH_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush_i,
  input  logic              resp_valid_i,
  input  logic              resp_keep_i,
  input  bus_pkg::word_t    resp_rdata_i,
  input  logic              fetch_ready_i,
  output logic              fetch_valid_o,
  output bus_pkg::word_t    fetch_rdata_o,
  output logic              space_o
);

  import bus_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  word_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] usage_q;

  logic empty;
  logic full;
  logic kept;
  logic push;
  logic pop;

  assign empty = (usage_q == '0);
  assign full  = (usage_q == CNT_W'(FIFO_DEPTH));

  // Response that survives abort and flush
  assign kept = resp_valid_i && resp_keep_i && !flush_i;

  ///////////////////////////////////////////////////
  // Decoder side
  ///////////////////////////////////////////////////

  // Head entry first, otherwise the response goes straight through
  assign fetch_valid_o = !flush_i && (!empty || kept);
  assign fetch_rdata_o = empty ? resp_rdata_i : mem[rd_ptr_q];

  assign pop  = !flush_i && !empty && fetch_ready_i;
  // Store only when the bypass cannot hand it over now
  assign push = kept && (!empty || !fetch_ready_i);

  // One slot reserved for the response already in flight
  assign space_o = (usage_q < CNT_W'(FIFO_DEPTH - 1)) && !full;

  ///////////////////////////////////////////////////
  // Pointers and usage
  ///////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      usage_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push) begin
        // Wrap at depth, depth need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({push, pop})
        2'b10:   usage_q <= usage_q + 1'b1;
        2'b01:   usage_q <= usage_q - 1'b1;
        default: usage_q <= usage_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= resp_rdata_i;
    end
  end

endmodule

//--- prefetch_buffer.sv
// Instruction prefetch buffer for a 32-bit fetch stage
// Joins fetch controller, memory port and instruction FIFO

module prefetch_buffer #(
  parameter int unsigned FIFO_DEPTH = prefetch_pkg::FIFO_DEPTH_DEF,
  parameter bit          PULP_OBI   = 1'b0
) (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              req_i,
  input  logic              branch_i,
  input  bus_pkg::addr_t    branch_addr_i,

  // Decoder side
  input  logic              fetch_ready_i,
  output logic              fetch_valid_o,
  output bus_pkg::word_t    fetch_rdata_o,

  // Instruction memory
  output logic              instr_req_o,
  input  logic              instr_gnt_i,
  output bus_pkg::addr_t    instr_addr_o,
  input  bus_pkg::word_t    instr_rdata_i,
  input  logic              instr_rvalid_i,

  output logic              busy_o
);

  import bus_pkg::*;

  // Controller to port
  logic  trans_valid;
  logic  trans_ready;
  addr_t trans_addr;

  // Port to FIFO
  logic  resp_valid;
  word_t resp_rdata;

  // Controller and FIFO
  logic  resp_keep;
  logic  fifo_space;

  ///////////////////////////////////////////////////
  // Fetch controller
  ///////////////////////////////////////////////////

  prefetch_ctrl u_prefetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .trans_ready_i (trans_ready),
    .resp_valid_i  (resp_valid),
    .fifo_space_i  (fifo_space),
    .trans_valid_o (trans_valid),
    .trans_addr_o  (trans_addr),
    .resp_keep_o   (resp_keep),
    .busy_o        (busy_o)
  );

  ///////////////////////////////////////////////////
  // Memory port
  ///////////////////////////////////////////////////

  obi_fetch_port #(
    .TRANS_STABLE_OFF (PULP_OBI)
  ) u_obi_fetch_port (
    .clk            (clk),
    .rst_n          (rst_n),
    .trans_valid_i  (trans_valid),
    .trans_addr_i   (trans_addr),
    .trans_ready_o  (trans_ready),
    .resp_valid_o   (resp_valid),
    .resp_rdata_o   (resp_rdata),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_rvalid_i (instr_rvalid_i)
  );

  ///////////////////////////////////////////////////
  // Instruction FIFO, flushed by every branch
  ///////////////////////////////////////////////////

  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fetch_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (branch_i),
    .resp_valid_i  (resp_valid),
    .resp_keep_i   (resp_keep),
    .resp_rdata_i  (resp_rdata),
    .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_rdata_o (fetch_rdata_o),
    .space_o       (fifo_space)
  );

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset source
// Period of 20 time units, reset held low for the first five cycles

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Released on a falling edge like every other stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (5) @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- tb_instr_mem.sv
// Instruction memory model for the prefetch buffer testbench
// Random grant and response delays, data derived from the word address

module tb_instr_mem (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           req_i,
  input  bus_pkg::addr_t addr_i,
  output logic           gnt_o,
  output bus_pkg::word_t rdata_o,
  output logic           rvalid_o,
  output int             stall_cnt_o,
  output int             err_cnt_o
);

  import bus_pkg::*;

  // One transaction in flight at most
  logic       pend_q;
  addr_t      pend_addr_q;
  logic [1:0] rv_cnt_q;
  logic [1:0] gnt_dly_q;
  // Request seen without grant so the address must hold
  logic       stalled_q;
  addr_t      held_addr_q;
  logic       rv_next;

  function automatic word_t mem_word(input addr_t addr);
    return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
  endfunction

  // Response due in the coming cycle
  assign rv_next = pend_q && (rv_cnt_q == 2'd1);

  // Quiet bus before the first clock edge
  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
  end

  ///////////////////////////////////////////////////
  // Outputs driven on the falling edge
  ///////////////////////////////////////////////////

  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= rv_next;
      rdata_o  <= rv_next ? mem_word(pend_addr_q) : '0;
      // Grant may overlap the response that frees the bus
      gnt_o    <= (gnt_dly_q == 2'd0) && (!pend_q || rv_next);
    end
  end

  ///////////////////////////////////////////////////
  // Transfer tracking on the rising edge
  ///////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q      <= 1'b0;
      pend_addr_q <= '0;
      rv_cnt_q    <= '0;
      gnt_dly_q   <= '0;
      stalled_q   <= 1'b0;
      held_addr_q <= '0;
      stall_cnt_o <= 0;
      err_cnt_o   <= 0;
    end else begin
      if (rvalid_o) begin
        pend_q <= 1'b0;
      end else if (pend_q) begin
        rv_cnt_q <= rv_cnt_q - 2'd1;
      end

      if (req_i && stalled_q && (addr_i != held_addr_q)) begin
        $display("ERR instr_addr_o held=%h now=%h", held_addr_q, addr_i);
        err_cnt_o <= err_cnt_o + 1;
      end

      if (req_i && !gnt_o) begin
        // Waited cycle counted for the stability check
        stall_cnt_o <= stall_cnt_o + 1;
        stalled_q   <= 1'b1;
        if (!stalled_q) begin
          held_addr_q <= addr_i;
        end
        if (gnt_dly_q != 2'd0) begin
          gnt_dly_q <= gnt_dly_q - 2'd1;
        end
      end else if (req_i) begin
        if (pend_q && !rvalid_o) begin
          $display("a second transfer was granted while one was still outstanding");
          err_cnt_o <= err_cnt_o + 1;
        end
        // Accepted transfer picks the latencies of this and the next one
        stalled_q   <= 1'b0;
        pend_q      <= 1'b1;
        pend_addr_q <= addr_i;
        rv_cnt_q    <= 2'($urandom_range(1, 3));
        gnt_dly_q   <= 2'($urandom_range(0, 2));
      end else if (stalled_q) begin
        $display("instr_req_o was withdrawn before its grant");
        err_cnt_o <= err_cnt_o + 1;
        stalled_q <= 1'b0;
      end
    end
  end

endmodule

//--- tb_prefetch_buffer.sv
// Testbench for the instruction prefetch buffer
// Random memory timing, decoder stalls and branches against a reference model

module tb_prefetch_buffer;

  import bus_pkg::*;

  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 2000;

  logic  clk;
  logic  rst_n;
  logic  req;
  logic  branch;
  addr_t branch_addr;
  logic  fetch_ready;
  logic  fetch_valid;
  word_t fetch_rdata;
  logic  instr_req;
  logic  instr_gnt;
  addr_t instr_addr;
  word_t instr_rdata;
  logic  instr_rvalid;
  logic  busy;

  // Checker state updated on the rising edge
  addr_t exp_addr    = '0;
  int    words_cnt   = 0;
  int    chk_err_cnt = 0;

  // Stimulus side bookkeeping
  int    err_cnt       = 0;
  int    busy_branches = 0;
  int    stall_cnt;
  int    mem_err_cnt;
  int    total_err;
  bit    timed_out     = 1'b0;

  tb_clk_gen u_tb_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  prefetch_buffer #(
    .FIFO_DEPTH (3),
    .PULP_OBI   (1'b0)
  ) u_prefetch_buffer (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .fetch_ready_i  (fetch_ready),
    .fetch_valid_o  (fetch_valid),
    .fetch_rdata_o  (fetch_rdata),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .instr_rvalid_i (instr_rvalid),
    .busy_o         (busy)
  );

  tb_instr_mem u_tb_instr_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (instr_req),
    .addr_i      (instr_addr),
    .gnt_o       (instr_gnt),
    .rdata_o     (instr_rdata),
    .rvalid_o    (instr_rvalid),
    .stall_cnt_o (stall_cnt),
    .err_cnt_o   (mem_err_cnt)
  );

  // Reference word for a byte address
  function automatic word_t expected_word(input addr_t addr);
    return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
  endfunction

  ///////////////////////////////////////////////////
  // Checker of every consumed word
  ///////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (branch) begin
        // Stream restarts at the word of the target
        exp_addr = branch_addr & ~32'h3;
        if (fetch_valid !== 1'b0) begin
          $display("ERR fetch_valid_o exp=0 got=%h in branch cycle", fetch_valid);
          chk_err_cnt++;
        end
      end else if (fetch_valid && fetch_ready) begin
        if (fetch_rdata !== expected_word(exp_addr)) begin
          $display("ERR fetch_rdata_o addr=%h exp=%h got=%h",
                   exp_addr, expected_word(exp_addr), fetch_rdata);
          chk_err_cnt++;
        end
        exp_addr = exp_addr + 32'd4;
        words_cnt++;
      end
    end
  end

  ///////////////////////////////////////////////////
  // Stimulus helpers entered and left on a falling edge
  ///////////////////////////////////////////////////

  task automatic check_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("ERR %s exp=0 got=%h", name, value);
      err_cnt++;
    end
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout while waiting for reset release");
      timed_out = 1'b1;
    end
    @(negedge clk);
  endtask

  // Branch is held for exactly one cycle
  task automatic issue_branch(input addr_t target);
    branch      = 1'b1;
    branch_addr = target;
    @(negedge clk);
    branch = 1'b0;
  endtask

  task automatic random_ready_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      fetch_ready = 1'($urandom_range(0, 1));
    end
  endtask

  task automatic wait_words(input int n, input bit rand_ready);
    int start;
    int cycles;
    start  = words_cnt;
    cycles = 0;
    while ((words_cnt - start) < n && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      if (rand_ready) begin
        fetch_ready = 1'($urandom_range(0, 1));
      end
      cycles++;
    end
    if ((words_cnt - start) < n) begin
      $display("timeout while waiting for %0d words, only %0d arrived", n, words_cnt - start);
      timed_out = 1'b1;
    end
  endtask

  // Used to land a branch while a transfer is in flight
  task automatic wait_busy();
    int cycles;
    cycles = 0;
    while (!busy && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      fetch_ready = 1'($urandom_range(0, 1));
      cycles++;
    end
    if (!busy) begin
      $display("timeout while waiting for busy_o to rise");
      timed_out = 1'b1;
    end
  endtask

  ///////////////////////////////////////////////////
  // Test sequence
  ///////////////////////////////////////////////////

  initial begin
    void'($urandom(4));
    req         = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    fetch_ready = 1'b0;
    wait_reset();

    // Nothing moves before req_i
    repeat (10) begin
      @(negedge clk);
      check_low("instr_req_o", instr_req);
      check_low("fetch_valid_o", fetch_valid);
      check_low("busy_o", busy);
    end
    $display("[1] idle after reset, errors so far %0d", err_cnt);

    if (!timed_out) begin
      req         = 1'b1;
      fetch_ready = 1'b1;
      issue_branch(32'h0000_1000);
      wait_words(40, 1'b0);
      $display("[2] sequential stream from 00001000, words %0d, errors so far %0d",
               words_cnt, chk_err_cnt);
    end

    // Decoder stalls at random
    if (!timed_out) begin
      issue_branch(32'h0004_2000);
      wait_words(60, 1'b1);
      $display("[3] stalled stream from 00042000, words %0d, errors so far %0d",
               words_cnt, chk_err_cnt);
    end

    // Even rounds branch while busy and odd ones after a random pause
    if (!timed_out) begin
      for (int i = 0; i < 16; i++) begin
        if (!timed_out) begin
          if (i % 2 == 0) begin
            wait_busy();
          end else begin
            random_ready_cycles(int'($urandom_range(0, 5)));
          end
        end
        if (!timed_out) begin
          if (busy) begin
            busy_branches++;
          end
          issue_branch($urandom);
          wait_words(1 + int'($urandom_range(0, 3)), 1'b1);
        end
      end
      $display("[4] random branches, %0d of 16 while busy, errors so far %0d",
               busy_branches, chk_err_cnt);
    end

    if (!timed_out) begin
      if (stall_cnt == 0) begin
        $display("no waited request cycle was seen on the bus");
        err_cnt++;
      end
      $display("[5] waited request cycles %0d, address errors %0d", stall_cnt, mem_err_cnt);
    end

    total_err = err_cnt + chk_err_cnt + mem_err_cnt;
    $display("words checked %0d, errors %0d, timeout %0d", words_cnt, total_err, timed_out);
    if (!timed_out && total_err == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- sources.f
bus_pkg.sv
prefetch_pkg.sv
obi_fetch_port.sv
prefetch_ctrl.sv
fetch_fifo.sv
prefetch_buffer.sv
tb_clk_gen.sv
tb_instr_mem.sv
tb_prefetch_buffer.sv

//--- run_sim.sh
#!/bin/sh
# Builds the prefetch buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary -j 0 -Wno-fatal --top-module tb_prefetch_buffer -f sources.f
./obj_dir/Vtb_prefetch_buffer > sim.log
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
exit 1
